/* common/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath and pc width
`define CORE_XLEN 32

// register number width, 32 integer registers
`define CORE_REG_AW 5

// first fetch address after reset
`define CORE_RESET_VECTOR 32'h0000_0000

// addi x0,x0,0
`define CORE_NOP 32'h0000_0013

`endif

/* common/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

	typedef logic [`CORE_XLEN-1:0]   word_t;     // data, pc or immediate
	typedef logic [31:0]             instr_t;
	typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

	// ten operations, encoded in four bits
	typedef enum logic [3:0]
	{
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	// fetch/decode register
	typedef struct packed
	{
		word_t  pc;
		instr_t instr;
	} fetch_t;

	// decode/execute register
	typedef struct packed
	{
		alu_op_e   alu_op;
		logic      a_pc;     // auipc
		logic      a_zero;   // lui
		logic      b_imm;
		logic      wen;      // low for bubbles
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t     rs1_data;
		word_t     rs2_data;
		word_t     imm;
		word_t     pc;
	} decoded_t;

	// one register write, also the execute/writeback register
	typedef struct packed
	{
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} retire_t;

endpackage

/* rtl/core_fetch.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_fetch import core_pkg::*;
(
	input  logic   clk_i,
	input  logic   reset_i,

	input  instr_t instr_i,       // returned in the same cycle
	output word_t  instr_addr_o,
	output fetch_t fetch_o
);

	word_t pc_q; // address being fetched this cycle

	assign instr_addr_o = pc_q;

	// no stalls or redirects, so the pc simply walks forward
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			pc_q <= `CORE_RESET_VECTOR;
		end
		else
		begin
			pc_q <= pc_q + word_t'(4);
		end
	end

	// capture the returned word together with the address it came from
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			fetch_o.pc    <= `CORE_RESET_VECTOR;
			fetch_o.instr <= `CORE_NOP; // decode sees a harmless nop first
		end
		else
		begin
			fetch_o.pc    <= pc_q;
			fetch_o.instr <= instr_i;
		end
	end

endmodule

/* rtl/core_regfile.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_regfile import core_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,

	input  reg_addr_t rs1_i,
	input  reg_addr_t rs2_i,
	output word_t     rs1_data_o,
	output word_t     rs2_data_o,

	input  retire_t   retire_i      // write port
);

	localparam int unsigned num_regs = 2 ** `CORE_REG_AW;

	word_t regs [num_regs];

	// written on the falling edge so decode reads the new value in the same cycle
	always_ff @(negedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end
		else if (retire_i.valid)
		begin
			regs[retire_i.rd] <= retire_i.data;
		end
	end

	// x0 is hardwired
	assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* decode/core_decode.sv */
`timescale 1ns/1ps

module core_decode import core_pkg::*;
(
	input  logic      clk_i,
	input  logic      reset_i,

	input  fetch_t    fetch_i,

	output reg_addr_t rs1_o,
	output reg_addr_t rs2_o,
	input  word_t     rs1_data_i,
	input  word_t     rs2_data_i,

	output decoded_t  decoded_o
);

	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;

	instr_t     instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_alt; // bit 30, sub and sra
	logic       supported;
	word_t      imm_i;
	word_t      imm_u;
	decoded_t   dec;

	// funct3 picks the operation, the alt bit splits add/sub and srl/sra
	function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic sub_sel,
			input logic sra_sel);
		case (f3)
			3'b000:  return sub_sel ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return sra_sel ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign instr      = fetch_i.instr;
	assign opcode     = instr[6:0];
	assign funct3     = instr[14:12];
	assign funct7_alt = instr[30];

	assign rs1_o = instr[19:15];
	assign rs2_o = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};

	always_comb
	begin
		dec          = '0;
		supported    = 1'b1;
		dec.rd       = instr[11:7];
		dec.rs1      = rs1_o;
		dec.rs2      = rs2_o;
		dec.rs1_data = rs1_data_i;
		dec.rs2_data = rs2_data_i;
		dec.pc       = fetch_i.pc;

		case (opcode)
			opc_op:
			begin
				dec.alu_op = funct_to_alu(funct3, funct7_alt, funct7_alt);
			end
			opc_op_imm:
			begin
				// bit 30 of addi is just immediate sign, only srai uses it
				dec.alu_op = funct_to_alu(funct3, 1'b0, funct7_alt);
				dec.b_imm  = 1'b1;
				dec.imm    = imm_i;
			end
			opc_lui:
			begin
				dec.a_zero = 1'b1; // 0 + imm
				dec.b_imm  = 1'b1;
				dec.imm    = imm_u;
			end
			opc_auipc:
			begin
				dec.a_pc  = 1'b1; // pc + imm
				dec.b_imm = 1'b1;
				dec.imm   = imm_u;
			end
			default:
			begin
				supported = 1'b0; // loads, stores, branches etc become bubbles
			end
		endcase

		dec.wen = supported && (dec.rd != '0);
	end

	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
			decoded_o <= '0; // bubble
		else
			decoded_o <= dec;
	end

endmodule

/* execute/core_execute.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_execute import core_pkg::*;
(
	input  logic     clk_i,
	input  logic     reset_i,

	input  decoded_t decoded_i,
	output retire_t  retire_o
);

	localparam int unsigned shamt_w = $clog2(`CORE_XLEN);

	word_t              rs1_val;
	word_t              rs2_val;
	word_t              op_a;
	word_t              op_b;
	word_t              result;
	logic [shamt_w-1:0] shamt;
	logic               fwd_rs1;
	logic               fwd_rs2;

	// the instruction ahead is sitting in the retire register and not yet in the
	// register file when decode read it
	assign fwd_rs1 = retire_o.valid && (retire_o.rd == decoded_i.rs1);
	assign fwd_rs2 = retire_o.valid && (retire_o.rd == decoded_i.rs2);

	assign rs1_val = fwd_rs1 ? retire_o.data : decoded_i.rs1_data;
	assign rs2_val = fwd_rs2 ? retire_o.data : decoded_i.rs2_data;

	always_comb
	begin
		if (decoded_i.a_pc)
			op_a = decoded_i.pc;
		else if (decoded_i.a_zero)
			op_a = '0;
		else
			op_a = rs1_val;
	end

	assign op_b  = decoded_i.b_imm ? decoded_i.imm : rs2_val;
	assign shamt = op_b[shamt_w-1:0];

	always_comb
	begin
		case (decoded_i.alu_op)
			alu_add:  result = op_a + op_b;
			alu_sub:  result = op_a - op_b;
			alu_sll:  result = op_a << shamt;
			alu_slt:  result = word_t'($signed(op_a) < $signed(op_b));
			alu_sltu: result = word_t'(op_a < op_b);
			alu_xor:  result = op_a ^ op_b;
			alu_srl:  result = op_a >> shamt;
			alu_sra:  result = $signed(op_a) >>> shamt; // keeps the sign bit
			alu_or:   result = op_a | op_b;
			alu_and:  result = op_a & op_b;
			default:  result = '0;
		endcase
	end

	// execute/writeback register, doubles as the retire record
	always_ff @(posedge clk_i or negedge reset_i)
	begin
		if (!reset_i)
		begin
			retire_o <= '0;
		end
		else
		begin
			retire_o.valid <= decoded_i.wen;
			retire_o.rd    <= decoded_i.rd;
			retire_o.data  <= result;
		end
	end

endmodule

/* rtl/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*;
(
	input  logic    clk_i,
	input  logic    reset_i,

	input  instr_t  instr_i,
	output word_t   instr_addr_o,

	output retire_t retire_o     // one record per register write
);

	fetch_t    fetch;
	decoded_t  decoded;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t     rs1_data;
	word_t     rs2_data;

	core_fetch i_core_fetch (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.instr_i      (instr_i),
		.instr_addr_o (instr_addr_o),
		.fetch_o      (fetch)
	);

	core_decode i_core_decode (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.fetch_i    (fetch),
		.rs1_o      (rs1),
		.rs2_o      (rs2),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.decoded_o  (decoded)
	);

	core_regfile i_core_regfile (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.rs1_i      (rs1),
		.rs2_i      (rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.retire_i   (retire_o)   // write port fed straight from the retire register
	);

	core_execute i_core_execute (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.decoded_i (decoded),
		.retire_o  (retire_o)
	);

endmodule

/* dv/core_asserts.sv */
`timescale 1ns/1ps

module core_asserts import core_pkg::*;
(
	input logic    clk_i,
	input logic    reset_i,
	input word_t   instr_addr_i,
	input retire_t retire_i
);

	int unsigned fail_count = 0; // failed assertions so far

	// decode turns every x0 write into a bubble
	property retire_rd_nonzero;
		@(posedge clk_i) disable iff (!reset_i)
		retire_i.valid |-> (retire_i.rd != '0);
	endproperty

	property fetch_aligned;
		@(posedge clk_i) disable iff (!reset_i)
		instr_addr_i[1:0] == 2'b00;
	endproperty

	// without stalls or redirects the pc walks one word per cycle
	property fetch_advances;
		@(posedge clk_i) disable iff (!reset_i)
		$past(reset_i) |-> (instr_addr_i == $past(instr_addr_i) + word_t'(4));
	endproperty

	property retire_known;
		@(posedge clk_i) disable iff (!reset_i)
		retire_i.valid |-> !$isunknown(retire_i);
	endproperty

	rd_nonzero_a: assert property (retire_rd_nonzero)
		else
		begin
			$error("retire valid with rd zero");
			fail_count++;
		end

	aligned_a: assert property (fetch_aligned)
		else
		begin
			$error("fetch address %h not word aligned", instr_addr_i);
			fail_count++;
		end

	advance_a: assert property (fetch_advances)
		else
		begin
			$error("fetch address %h did not advance by four", instr_addr_i);
			fail_count++;
		end

	known_a: assert property (retire_known)
		else
		begin
			$error("retire record has unknown bits while valid");
			fail_count++;
		end

endmodule

bind core_top core_asserts i_core_asserts
(
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.instr_addr_i (instr_addr_o),
	.retire_i     (retire_o)
);

/* dv/core_tb.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_tb import core_pkg::*;
();

	localparam int num_records    = 32;
	localparam int retire_timeout = 20; // cycles per record
	localparam int drain_cycles   = 10;

	logic    clk_i;
	logic    reset_i;
	instr_t  instr;
	word_t   instr_addr;
	retire_t retire;

	// three words per record for instruction, expected rd and expected value
	word_t prog [3*num_records];

	core_top i_core_top
	(
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.instr_i      (instr),
		.instr_addr_o (instr_addr),
		.retire_o     (retire)
	);

	// 20 ns period
	always #10 clk_i = ~clk_i;

	// instruction memory that reads a nop past the program
	function automatic instr_t fetch_word(input word_t addr);
		int unsigned idx;
		idx = addr >> 2;
		if (idx < num_records)
			return prog[3*idx];
		else
			return `CORE_NOP;
	endfunction

	// address is stable since the rising edge and the word is sampled at the next one
	always @(negedge clk_i)
		instr <= fetch_word(instr_addr);

	// a failed bound assertion ends the run as well
	always @(negedge clk_i)
	begin
		if (i_core_top.i_core_asserts.fail_count != 0)
		begin
			$display("a bound assertion on core_top failed before %0t", $time);
			$display("TESTBENCH FAILED");
			$fatal(1, "assertion failure");
		end
	end

	task automatic check_equal(input string what, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s, expected %h, got %h", $time, what, expected,
				actual);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// polls on falling edges where the retire register is settled
	task automatic wait_for_retire(input int record);
		int cycles;
		cycles = 0;
		@(negedge clk_i);
		while (retire.valid !== 1'b1)
		begin
			cycles++;
			if (cycles > retire_timeout)
			begin
				$display("record %0d at pc %h never retired within %0d cycles", record,
					record * 4, retire_timeout);
				$display("TESTBENCH FAILED");
				$fatal(1, "retire timeout");
			end
			@(negedge clk_i);
		end
	endtask

	initial
	begin
		int n_checked;
		n_checked = 0;
		clk_i     = 1'b0;
		reset_i   = 1'b0;
		instr     = `CORE_NOP;
		$readmemh("dv/core_input.hex", prog);

		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		reset_i = 1'b1;

		// each retire must match the next record that expects one, so
		// bubbles and reordering both show up as a mismatch
		for (int r = 0; r < num_records; r++)
		begin
			if (prog[3*r+1] != '0)
			begin
				wait_for_retire(r);
				check_equal($sformatf("rd of record %0d", r), prog[3*r+1],
					word_t'(retire.rd));
				check_equal($sformatf("value of record %0d", r), prog[3*r+2],
					retire.data);
				n_checked++;
			end
		end

		// pipeline runs on nops now so nothing else may retire
		repeat (drain_cycles)
		begin
			@(negedge clk_i);
			check_equal("retire valid after last record", '0, word_t'(retire.valid));
		end

		if (n_checked > 0 && i_core_top.i_core_asserts.fail_count == 0)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
		begin
			if (n_checked == 0)
				$display("data file dv/core_input.hex held no records to check");
			else
				$display("a bound assertion on core_top failed");
			$display("TESTBENCH FAILED");
			$fatal(1, "run failed");
		end
	end

endmodule

/* verilog.f */
+incdir+common
common/core_pkg.sv
rtl/core_fetch.sv
rtl/core_regfile.sv
decode/core_decode.sv
execute/core_execute.sv
rtl/core_top.sv
dv/core_asserts.sv
dv/core_tb.sv

/* dv/core_input.hex */
// columns: instruction word, expected rd, expected rd value
// an expected rd of 00 means the instruction must not retire
// record n sits at pc 4*n

// register-immediate group
00500093 01 00000005 // addi  x1, x0, 5
FFD00113 02 FFFFFFFD // addi  x2, x0, -3
00112193 03 00000001 // slti  x3, x2, 1
00113213 04 00000000 // sltiu x4, x2, 1
FFF0C293 05 FFFFFFFA // xori  x5, x1, -1
0F00E313 06 000000F5 // ori   x6, x1, 0x0f0
03C37393 07 00000034 // andi  x7, x6, 0x03c
00409413 08 00000050 // slli  x8, x1, 4
01C15493 09 0000000F // srli  x9, x2, 28
40115513 0A FFFFFFFE // srai  x10, x2, 1

// register-register group
002085B3 0B 00000002 // add   x11, x1, x2
40208633 0C 00000008 // sub   x12, x1, x2
001126B3 0D 00000001 // slt   x13, x2, x1
00113733 0E 00000000 // sltu  x14, x2, x1
401157B3 0F FFFFFFFF // sra   x15, x2, x1
00115833 10 07FFFFFF // srl   x16, x2, x1
001098B3 11 000000A0 // sll   x17, x1, x1
0060C933 12 000000F0 // xor   x18, x1, x6
001169B3 13 FFFFFFFD // or    x19, x2, x1
00617A33 14 000000F5 // and   x20, x2, x6

// dependent chain, the last one reads x21 two behind its writer
00100A93 15 00000001 // addi  x21, x0, 1
015A8AB3 15 00000002 // add   x21, x21, x21
015A8B33 16 00000004 // add   x22, x21, x21
016A8BB3 17 00000006 // add   x23, x21, x22

// upper immediates
12345C37 18 12345000 // lui   x24, 0x12345
00001C97 19 00001064 // auipc x25, 0x1
FFFFFD17 1A FFFFF068 // auipc x26, 0xfffff

// bubbles, then x0 read back
00708013 00 00000000 // addi  x0, x1, 7
00112023 00 00000000 // sw    x1, 0(x2)
00108463 00 00000000 // beq   x1, x1, 8
00100DB3 1B 00000005 // add   x27, x0, x1
FFAD8E13 1C FFFFFFFF // addi  x28, x27, -6
